// File: include/branch_config.svh
`ifndef BRANCH_CONFIG_SVH
`define BRANCH_CONFIG_SVH

// ====================
// branch unit sizing
// ====================

// data and address width.
`define BR_XLEN 32

// rob tag width.
`define BR_ROB_BITS 4

// station depth, 2, 4 or 8.
`define BR_RS_ENTRIES 4

`endif

// File: design/branchIsaPkg.sv
`include "branch_config.svh"

package branchIsaPkg;

  // ====================
  // branch opcodes
  // ====================
  typedef enum logic [2:0] {
    BEQ  = 3'd0,
    BNE  = 3'd1,
    BLT  = 3'd2,
    BGE  = 3'd3,
    BLTU = 3'd4,
    BGEU = 3'd5,
    JAL  = 3'd6,
    JALR = 3'd7
  } branchOpE;

  typedef logic [`BR_XLEN-1:0] xlenT;

  // signed view of a word for blt and bge.
  typedef logic signed [`BR_XLEN-1:0] sxlenT;

  // compare results of one operand pair.
  typedef struct packed {
    logic eq;
    logic lt;   // signed.
    logic ltu;  // unsigned.
  } cmpFlagsT;

endpackage

// File: design/rsPkg.sv
`include "branch_config.svh"

package rsPkg;

  // ====================
  // entry state
  // ====================
  typedef enum logic [1:0] {
    EMPTY   = 2'd0,
    WAITING = 2'd1,
    READY   = 2'd2
  } entryStateE;

  // ====================
  // station widths
  // ====================

  // rob tag, also used on the cdb.
  typedef logic [`BR_ROB_BITS-1:0] robTagT;

  // one bit per station entry.
  typedef logic [`BR_RS_ENTRIES-1:0] entryMaskT;

endpackage

// File: design/rsWriteIf.sv
`timescale 1ns/1ps

interface rsWriteIf;
  import rsPkg::*;
  import branchIsaPkg::*;

  entryMaskT writeReq;  // one-hot, single-cycle strobe.
  branchOpE  op;
  robTagT    rob;
  xlenT      src1;
  xlenT      src2;
  logic      ready1;
  logic      ready2;
  robTagT    tag1;
  robTagT    tag2;
  xlenT      predictedPc;
  xlenT      target;
  xlenT      seqPc;

  modport dispatcher (output writeReq, op, rob, src1, src2, ready1, ready2,
                      tag1, tag2, predictedPc, target, seqPc);
  modport station (input writeReq, op, rob, src1, src2, ready1, ready2,
                   tag1, tag2, predictedPc, target, seqPc);
endinterface

// File: design/branchIssueIf.sv
`timescale 1ns/1ps

interface branchIssueIf;
  import rsPkg::*;
  import branchIsaPkg::*;

  logic     issueValid;  // one pulse per issued branch.
  robTagT   rob;
  branchOpE op;
  xlenT     src1;
  xlenT     src2;
  xlenT     predictedPc;
  xlenT     target;
  xlenT     seqPc;

  modport issuer (output issueValid, rob, op, src1, src2, predictedPc, target,
                  seqPc);
  modport executor (input issueValid, rob, op, src1, src2, predictedPc, target,
                    seqPc);

endinterface

// File: design/branchDispatch.sv
`timescale 1ns/1ps

module branchDispatch (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   dispatchValid,
  input  branchIsaPkg::branchOpE dispatchOp,
  input  rsPkg::robTagT          dispatchRob,
  input  branchIsaPkg::xlenT     dispatchSrc1,
  input  branchIsaPkg::xlenT     dispatchSrc2,
  input  logic                   dispatchReady1,
  input  logic                   dispatchReady2,
  input  rsPkg::robTagT          dispatchTag1,
  input  rsPkg::robTagT          dispatchTag2,
  input  branchIsaPkg::xlenT     dispatchPredictedPc,
  input  branchIsaPkg::xlenT     dispatchTarget,
  input  branchIsaPkg::xlenT     dispatchSeqPc,
  input  logic                   cdbValid,
  input  rsPkg::robTagT          cdbRob,
  input  branchIsaPkg::xlenT     cdbValue,
  input  rsPkg::entryMaskT       busy,
  output logic                   dispatchFull,
  rsWriteIf.dispatcher           wr
);
  import rsPkg::*;

  entryMaskT freeOneHot;
  logic      bypass1;
  logic      bypass2;

  // lowest clear bit of busy, zero when full.
  assign freeOneHot   = ~busy & (busy + 1'b1);
  assign dispatchFull = &busy;

  // same-cycle cdb snoop.
  assign bypass1 = cdbValid && !dispatchReady1 && (cdbRob == dispatchTag1);
  assign bypass2 = cdbValid && !dispatchReady2 && (cdbRob == dispatchTag2);

  assign wr.writeReq    = dispatchValid ? freeOneHot : '0;
  assign wr.op          = dispatchOp;
  assign wr.rob         = dispatchRob;
  assign wr.src1        = bypass1 ? cdbValue : dispatchSrc1;
  assign wr.src2        = bypass2 ? cdbValue : dispatchSrc2;
  assign wr.ready1      = dispatchReady1 | bypass1;
  assign wr.ready2      = dispatchReady2 | bypass2;
  assign wr.tag1        = dispatchTag1;
  assign wr.tag2        = dispatchTag2;
  assign wr.predictedPc = dispatchPredictedPc;
  assign wr.target      = dispatchTarget;
  assign wr.seqPc       = dispatchSeqPc;

  // rename has to hold off while the station is full.
  noDispatchWhenFull: assert property (
    @(posedge clk) disable iff (!arstN) dispatchValid |-> !dispatchFull
  ) else $error("branchDispatch: dispatch while station full");

endmodule

// File: design/branchRSEntry.sv
`timescale 1ns/1ps

module branchRSEntry #(
  parameter int unsigned entryIdx = 0
) (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   flush,
  input  logic                   cdbValid,
  input  rsPkg::robTagT          cdbRob,
  input  branchIsaPkg::xlenT     cdbValue,
  input  logic                   selected,
  rsWriteIf.station              wr,
  output logic                   busy,
  output logic                   selectReq,
  output rsPkg::robTagT          rob,
  output branchIsaPkg::branchOpE op,
  output branchIsaPkg::xlenT     src1,
  output branchIsaPkg::xlenT     src2,
  output branchIsaPkg::xlenT     predictedPc,
  output branchIsaPkg::xlenT     target,
  output branchIsaPkg::xlenT     seqPc
);
  import rsPkg::*;

  entryStateE state;
  logic       load;
  logic       ready1;
  logic       ready2;
  robTagT     tag1;
  robTagT     tag2;
  logic       wake1;
  logic       wake2;

  assign load  = wr.writeReq[entryIdx];
  assign wake1 = cdbValid && !ready1 && (cdbRob == tag1);
  assign wake2 = cdbValid && !ready2 && (cdbRob == tag2);

  assign busy      = (state != EMPTY);
  assign selectReq = (state == READY);

  // ====================
  // entry state machine
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= EMPTY;
    end else if (flush) begin
      state <= EMPTY;
    end else begin
      case (state)
        EMPTY:   if (load) state <= (wr.ready1 && wr.ready2) ? READY : WAITING;
        WAITING: if ((ready1 || wake1) && (ready2 || wake2)) state <= READY;
        READY:   if (selected) state <= EMPTY;
        default: state <= EMPTY;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      rob         <= wr.rob;
      op          <= wr.op;
      src1        <= wr.src1;
      src2        <= wr.src2;
      ready1      <= wr.ready1;
      ready2      <= wr.ready2;
      tag1        <= wr.tag1;
      tag2        <= wr.tag2;
      predictedPc <= wr.predictedPc;
      target      <= wr.target;
      seqPc       <= wr.seqPc;
    end else begin
      if (wake1) begin
        src1   <= cdbValue;
        ready1 <= 1'b1;
      end
      if (wake2) begin
        src2   <= cdbValue;
        ready2 <= 1'b1;
      end
    end
  end

  selectOnlyReady: assert property (
    @(posedge clk) disable iff (!arstN) selected |-> state == READY
  ) else $error("branchRSEntry: grant to entry not ready");

  // dispatch must only target a free entry.
  writeOnlyEmpty: assert property (
    @(posedge clk) disable iff (!arstN) load |-> state == EMPTY
  ) else $error("branchRSEntry: write into occupied entry");

endmodule

// File: design/branchSelect.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branchSelect (
  input  logic             clk,
  input  logic             arstN,
  input  logic             flush,
  input  rsPkg::entryMaskT writeReq,
  input  rsPkg::entryMaskT requests,
  output rsPkg::entryMaskT grants
);
  import rsPkg::*;

  // olderThan[i][j] set when entry i was written before entry j.
  entryMaskT olderThan [`BR_RS_ENTRIES];

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 0; i < `BR_RS_ENTRIES; i++) begin
        olderThan[i] <= '0;
      end
    end else if (flush) begin
      for (int i = 0; i < `BR_RS_ENTRIES; i++) begin
        olderThan[i] <= '0;
      end
    end else begin
      for (int i = 0; i < `BR_RS_ENTRIES; i++) begin
        if (writeReq[i]) olderThan[i] <= '0;            // newest entry.
        else             olderThan[i] <= olderThan[i] | writeReq;
      end
    end
  end

  always_comb begin
    logic blocked;
    grants = '0;
    for (int i = 0; i < `BR_RS_ENTRIES; i++) begin
      blocked = 1'b0;
      for (int j = 0; j < `BR_RS_ENTRIES; j++) begin
        if (j != i && requests[j] && olderThan[j][i]) blocked = 1'b1;
      end
      grants[i] = requests[i] && !blocked;
    end
  end

  grantOneHot: assert property (
    @(posedge clk) disable iff (!arstN) $onehot0(grants)
  ) else $error("branchSelect: more than one grant");

endmodule

// File: design/branchRS.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branchRS (
  input  logic               clk,
  input  logic               arstN,
  input  logic               flush,
  input  logic               cdbValid,
  input  rsPkg::robTagT      cdbRob,
  input  branchIsaPkg::xlenT cdbValue,
  rsWriteIf.station          wr,
  output rsPkg::entryMaskT   busy,
  branchIssueIf.issuer       issue
);
  import rsPkg::*;
  import branchIsaPkg::*;

  entryMaskT requests;
  entryMaskT grants;

  robTagT   entryRob         [`BR_RS_ENTRIES];
  branchOpE entryOp          [`BR_RS_ENTRIES];
  xlenT     entrySrc1        [`BR_RS_ENTRIES];
  xlenT     entrySrc2        [`BR_RS_ENTRIES];
  xlenT     entryPredictedPc [`BR_RS_ENTRIES];
  xlenT     entryTarget      [`BR_RS_ENTRIES];
  xlenT     entrySeqPc       [`BR_RS_ENTRIES];

  robTagT   robSel;
  branchOpE opSel;
  xlenT     src1Sel;
  xlenT     src2Sel;
  xlenT     predictedPcSel;
  xlenT     targetSel;
  xlenT     seqPcSel;

  // ====================
  // entries and select
  // ====================
  for (genvar g = 0; g < `BR_RS_ENTRIES; g++) begin : gEntry
    branchRSEntry #(.entryIdx(g)) entryInst (
      .clk, .arstN, .flush, .cdbValid, .cdbRob, .cdbValue,
      .selected    (grants[g]),
      .wr          (wr),
      .busy        (busy[g]),
      .selectReq   (requests[g]),
      .rob         (entryRob[g]),
      .op          (entryOp[g]),
      .src1        (entrySrc1[g]),
      .src2        (entrySrc2[g]),
      .predictedPc (entryPredictedPc[g]),
      .target      (entryTarget[g]),
      .seqPc       (entrySeqPc[g])
    );
  end

  branchSelect selectInst (
    .clk, .arstN, .flush,
    .writeReq (wr.writeReq),
    .requests (requests),
    .grants   (grants)
  );

  // granted entry fields.
  always_comb begin
    robSel         = '0;
    opSel          = BEQ;
    src1Sel        = '0;
    src2Sel        = '0;
    predictedPcSel = '0;
    targetSel      = '0;
    seqPcSel       = '0;
    for (int i = 0; i < `BR_RS_ENTRIES; i++) begin
      if (grants[i]) begin
        robSel         = entryRob[i];
        opSel          = entryOp[i];
        src1Sel        = entrySrc1[i];
        src2Sel        = entrySrc2[i];
        predictedPcSel = entryPredictedPc[i];
        targetSel      = entryTarget[i];
        seqPcSel       = entrySeqPc[i];
      end
    end
  end

  // ====================
  // issue register
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)     issue.issueValid <= 1'b0;
    else if (flush) issue.issueValid <= 1'b0;
    else            issue.issueValid <= |grants;
  end

  always_ff @(posedge clk) begin
    if (|grants) begin
      issue.rob         <= robSel;
      issue.op          <= opSel;
      issue.src1        <= src1Sel;
      issue.src2        <= src2Sel;
      issue.predictedPc <= predictedPcSel;
      issue.target      <= targetSel;
      issue.seqPc       <= seqPcSel;
    end
  end

endmodule

// File: design/branchExecute.sv
`timescale 1ns/1ps

module branchExecute (
  input  logic               clk,
  input  logic               arstN,
  input  logic               flush,
  branchIssueIf.executor     issue,
  output logic               resolveValid,
  output rsPkg::robTagT      resolveRob,
  output branchIsaPkg::xlenT resolveNextPc,
  output logic               resolveMispredict,
  output branchIsaPkg::xlenT resolveLink
);
  import branchIsaPkg::*;

  cmpFlagsT cmp;
  logic     taken;
  xlenT     jalrSum;
  xlenT     takenPc;
  xlenT     nextPc;

  assign cmp.eq  = (issue.src1 == issue.src2);
  assign cmp.lt  = (sxlenT'(issue.src1) < sxlenT'(issue.src2));
  assign cmp.ltu = (issue.src1 < issue.src2);

  // ====================
  // branch decision
  // ====================
  always_comb begin
    case (issue.op)
      BEQ:     taken = cmp.eq;
      BNE:     taken = !cmp.eq;
      BLT:     taken = cmp.lt;
      BGE:     taken = !cmp.lt;
      BLTU:    taken = cmp.ltu;
      BGEU:    taken = !cmp.ltu;
      default: taken = 1'b1;  // jal, jalr.
    endcase
  end

  assign jalrSum = issue.src1 + issue.target;
  assign takenPc = (issue.op == JALR) ? (jalrSum & ~xlenT'(1)) : issue.target;
  assign nextPc  = taken ? takenPc : issue.seqPc;

  // ====================
  // result register
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN)     resolveValid <= 1'b0;
    else if (flush) resolveValid <= 1'b0;
    else            resolveValid <= issue.issueValid;
  end

  always_ff @(posedge clk) begin
    if (issue.issueValid) begin
      resolveRob        <= issue.rob;
      resolveNextPc     <= nextPc;
      resolveMispredict <= (nextPc != issue.predictedPc);
      resolveLink       <= issue.seqPc;  // return address.
    end
  end

endmodule

// File: design/branchUnitTop.sv
`timescale 1ns/1ps

module branchUnitTop (
  input  logic                   clk,
  input  logic                   arstN,
  input  logic                   flush,
  input  logic                   dispatchValid,
  input  branchIsaPkg::branchOpE dispatchOp,
  input  rsPkg::robTagT          dispatchRob,
  input  branchIsaPkg::xlenT     dispatchSrc1,
  input  branchIsaPkg::xlenT     dispatchSrc2,
  input  logic                   dispatchReady1,
  input  logic                   dispatchReady2,
  input  rsPkg::robTagT          dispatchTag1,
  input  rsPkg::robTagT          dispatchTag2,
  input  branchIsaPkg::xlenT     dispatchPredictedPc,
  input  branchIsaPkg::xlenT     dispatchTarget,
  input  branchIsaPkg::xlenT     dispatchSeqPc,
  output logic                   dispatchFull,
  input  logic                   cdbValid,
  input  rsPkg::robTagT          cdbRob,
  input  branchIsaPkg::xlenT     cdbValue,
  output logic                   resolveValid,
  output rsPkg::robTagT          resolveRob,
  output branchIsaPkg::xlenT     resolveNextPc,
  output logic                   resolveMispredict,
  output branchIsaPkg::xlenT     resolveLink
);
  import rsPkg::*;

  entryMaskT busy;

  rsWriteIf     wrBus ();
  branchIssueIf issueBus ();

  // producer.
  branchDispatch branchDispatch_inst (
    .clk, .arstN, .dispatchValid, .dispatchOp, .dispatchRob,
    .dispatchSrc1, .dispatchSrc2, .dispatchReady1, .dispatchReady2,
    .dispatchTag1, .dispatchTag2, .dispatchPredictedPc, .dispatchTarget,
    .dispatchSeqPc, .cdbValid, .cdbRob, .cdbValue, .busy, .dispatchFull,
    .wr (wrBus)
  );

  branchRS branchRS_inst (
    .clk, .arstN, .flush, .cdbValid, .cdbRob, .cdbValue, .busy,
    .wr    (wrBus),
    .issue (issueBus)
  );

  // consumer, always accepts.
  branchExecute branchExecute_inst (
    .clk, .arstN, .flush,
    .issue (issueBus),
    .resolveValid, .resolveRob, .resolveNextPc, .resolveMispredict, .resolveLink
  );

endmodule

// File: dv/branchUnitTb.sv
`timescale 1ns/1ps
`include "branch_config.svh"

module branchUnitTb;
  import branchIsaPkg::*;
  import rsPkg::*;

  typedef struct packed {
    xlenT nextPc;
    logic mispredict;
    xlenT link;
  } resultT;

  localparam int NumTags = 1 << `BR_ROB_BITS;

  logic     clk;
  logic     arstN;
  logic     flush;
  logic     dispatchValid;
  branchOpE dispatchOp;
  robTagT   dispatchRob;
  xlenT     dispatchSrc1;
  xlenT     dispatchSrc2;
  logic     dispatchReady1;
  logic     dispatchReady2;
  robTagT   dispatchTag1;
  robTagT   dispatchTag2;
  xlenT     dispatchPredictedPc;
  xlenT     dispatchTarget;
  xlenT     dispatchSeqPc;
  logic     dispatchFull;
  logic     cdbValid;
  robTagT   cdbRob;
  xlenT     cdbValue;
  logic     resolveValid;
  robTagT   resolveRob;
  xlenT     resolveNextPc;
  logic     resolveMispredict;
  xlenT     resolveLink;

  // scoreboard indexed by rob tag.
  resultT expRes     [NumTags];
  bit     pending    [NumTags];
  bit     fastChk    [NumTags];
  bit     inOrder    [NumTags];
  bit     opPending1 [NumTags];
  bit     opPending2 [NumTags];
  robTagT waitTag1   [NumTags];
  robTagT waitTag2   [NumTags];
  int     dispCycle  [NumTags];
  xlenT   tagValue   [NumTags];  // value each producer tag broadcasts.
  robTagT orderQ     [$];

  int          cycle;
  int          lastOrderCycle;
  int          checks;
  int          errors;
  logic [31:0] lfsr;

  branchUnitTop branchUnitTop_inst (.*);

  always #5 clk = ~clk;

  // ====================
  // random and reference
  // ====================
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsrNext(lfsr);
    end
    return v;
  endfunction

  function automatic resultT branchRef(input branchOpE op, input xlenT a, input xlenT b,
                                       input xlenT pred, input xlenT tgt, input xlenT seq);
    resultT res;
    logic   taken;
    xlenT   sum;
    xlenT   dest;
    case (op)
      BEQ:     taken = (a == b);
      BNE:     taken = (a != b);
      BLT:     taken = ($signed(a) < $signed(b));
      BGE:     taken = ($signed(a) >= $signed(b));
      BLTU:    taken = (a < b);
      BGEU:    taken = (a >= b);
      default: taken = 1'b1;
    endcase
    sum  = a + tgt;
    dest = (op == JALR) ? {sum[`BR_XLEN-1:1], 1'b0} : tgt;
    res.nextPc     = taken ? dest : seq;
    res.mispredict = (res.nextPc != pred);
    res.link       = seq;
    return res;
  endfunction

  function automatic bit anyPending();
    for (int r = 0; r < NumTags; r++) begin
      if (pending[r]) return 1'b1;
    end
    return 1'b0;
  endfunction

  // ====================
  // driver tasks
  // ====================
  task automatic abortRun(input string why);
    $display("TIMEOUT @%0t: %s", $time, why);
    $display("Verification failed");
    $finish;
  endtask

  task automatic idleCycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic dispatchBranch(input robTagT rob, input branchOpE op, input xlenT a,
                                input xlenT b, input logic r1, input logic r2,
                                input robTagT t1, input robTagT t2, input bit fast,
                                input bit ordered);
    xlenT seq;
    xlenT tgt;
    xlenT pred;
    int   spins;
    spins = 0;
    while (dispatchFull) begin
      idleCycles(1);
      spins++;
      if (spins > 100) abortRun("station never freed an entry for dispatch");
    end
    seq  = randBits(30) << 2;
    tgt  = randBits(32);
    pred = (randBits(1) != 0) ? tgt : seq;
    dispatchValid       = 1'b1;
    dispatchOp          = op;
    dispatchRob         = rob;
    dispatchSrc1        = r1 ? a : ~a;  // stale until woken.
    dispatchSrc2        = r2 ? b : ~b;
    dispatchReady1      = r1;
    dispatchReady2      = r2;
    dispatchTag1        = t1;
    dispatchTag2        = t2;
    dispatchPredictedPc = pred;
    dispatchTarget      = tgt;
    dispatchSeqPc       = seq;
    expRes[rob]     = branchRef(op, a, b, pred, tgt, seq);
    pending[rob]    = 1'b1;
    fastChk[rob]    = fast;
    inOrder[rob]    = ordered;
    opPending1[rob] = !r1 && !(cdbValid && cdbRob == t1);  // same-cycle bypass counts.
    opPending2[rob] = !r2 && !(cdbValid && cdbRob == t2);
    waitTag1[rob]   = t1;
    waitTag2[rob]   = t2;
    if (!r1) tagValue[t1] = a;
    if (!r2) tagValue[t2] = b;
    if (ordered) orderQ.push_back(rob);
    idleCycles(1);
    dispatchValid = 1'b0;
  endtask

  task automatic broadcastTag(input robTagT tag);
    for (int r = 0; r < NumTags; r++) begin
      if (pending[r] && opPending1[r] && waitTag1[r] == tag) opPending1[r] = 1'b0;
      if (pending[r] && opPending2[r] && waitTag2[r] == tag) opPending2[r] = 1'b0;
    end
    cdbValid = 1'b1;
    cdbRob   = tag;
    cdbValue = tagValue[tag];
    idleCycles(1);
    cdbValid = 1'b0;
  endtask

  // negative rob waits for everything.
  task automatic waitDrained(input int rob);
    int spins;
    spins = 0;
    while ((rob < 0) ? anyPending() : pending[rob]) begin
      idleCycles(1);
      spins++;
      if (spins > 200) abortRun("pending branches never resolved");
    end
  endtask

  task automatic reportTest(input string name, input int errBefore);
    if (errors == errBefore) $display("test %s: ok", name);
    else $display("test %s: %0d errors", name, errors - errBefore);
  endtask

  // ====================
  // compare process
  // ====================
  always @(posedge clk) begin
    resultT got;
    robTagT r;
    if (arstN) begin
      if (dispatchValid) dispCycle[dispatchRob] = cycle;
      if (resolveValid) begin
        r   = resolveRob;
        got = {resolveNextPc, resolveMispredict, resolveLink};
        checks++;
        if (!pending[r]) begin
          errors++;
          $display("ERROR @%0t: rob %0d resolved with no branch pending", $time, r);
        end else begin
          if (opPending1[r] || opPending2[r]) begin
            errors++;
            $display("ERROR @%0t: rob %0d resolved before its tags", $time, r);
          end
          if (fastChk[r] && cycle - dispCycle[r] != 3) begin
            errors++;
            $display("ERROR @%0t: rob %0d took %0d cycles, expected 3", $time, r,
                     cycle - dispCycle[r]);
          end
          if (inOrder[r]) begin
            if (orderQ.size() == 0 || orderQ[0] != r) begin
              errors++;
              $display("ERROR @%0t: rob %0d out of age order", $time, r);
            end else begin
              orderQ.delete(0);
            end
            if (lastOrderCycle != 0 && cycle != lastOrderCycle + 1) begin
              errors++;
              $display("ERROR @%0t: gap before rob %0d in oldest-first run", $time, r);
            end
            lastOrderCycle = cycle;
          end
          if (got != expRes[r]) begin
            errors++;
            $display("ERROR @%0t: rob %0d got pc %h mis %0b link %h, expected %h %0b %h",
                     $time, r, got.nextPc, got.mispredict, got.link, expRes[r].nextPc,
                     expRes[r].mispredict, expRes[r].link);
          end
          pending[r] = 1'b0;
        end
      end
    end
    cycle++;
  end

  // ====================
  // test sequence
  // ====================
  initial begin
    int     errBefore;
    int     k;
    int     spins;
    xlenT   a;
    xlenT   b;
    robTagT order [8];
    robTagT tmp;
    clk = 1'b0;
    arstN = 1'b0;
    flush = 1'b0;
    dispatchValid = 1'b0;
    dispatchOp = BEQ;
    dispatchRob = '0;
    dispatchSrc1 = '0;
    dispatchSrc2 = '0;
    dispatchReady1 = 1'b0;
    dispatchReady2 = 1'b0;
    dispatchTag1 = '0;
    dispatchTag2 = '0;
    dispatchPredictedPc = '0;
    dispatchTarget = '0;
    dispatchSeqPc = '0;
    cdbValid = 1'b0;
    cdbRob = '0;
    cdbValue = '0;
    lfsr = 32'd95;
    cycle = 0;
    lastOrderCycle = 0;
    checks = 0;
    errors = 0;
    repeat (10) @(posedge clk);
    #1;
    arstN = 1'b1;
    idleCycles(1);

    // every opcode against equal, negative and large operand pairs.
    errBefore = errors;
    for (int i = 0; i < 40; i++) begin
      a = randBits(32);
      case ((i / 8) % 4)
        0: b = a;
        1: begin
          a[31] = 1'b1;
          b = randBits(16);
        end
        2: begin
          a[31] = 1'b1;
          b = randBits(32) | 32'h8000_0000;
        end
        default: b = randBits(32);
      endcase
      dispatchBranch(robTagT'(i), branchOpE'(i % 8), a, b, 1, 1, 0, 0, 1, 0);
    end
    waitDrained(-1);
    reportTest("all opcodes, ready operands", errBefore);

    errBefore = errors;
    for (int i = 0; i < 4; i++) begin
      order[2*i]   = robTagT'(8 + 2*i);
      order[2*i+1] = robTagT'(9 + 2*i);
      a = randBits(32);
      b = randBits(32);
      dispatchBranch(robTagT'(i), branchOpE'(randBits(3)), a, b, 0, 0,
                     robTagT'(8 + 2*i), robTagT'(9 + 2*i), 0, 0);
    end
    for (int i = 7; i > 0; i--) begin
      k = randBits(3) % (i + 1);
      tmp = order[i];
      order[i] = order[k];
      order[k] = tmp;
    end
    for (int i = 0; i < 8; i++) begin
      idleCycles(randBits(2));
      broadcastTag(order[i]);
    end
    waitDrained(-1);
    reportTest("wakeup from the cdb", errBefore);

    errBefore = errors;
    for (int i = 0; i < 6; i++) begin
      a = randBits(32);
      b = randBits(32);
      cdbValid = 1'b1;
      cdbRob   = robTagT'(8 + i);
      cdbValue = (i % 2) ? b : a;
      if (i % 2) dispatchBranch(robTagT'(i), branchOpE'(randBits(3)), a, b, 1, 0,
                                0, robTagT'(8 + i), 1, 0);
      else dispatchBranch(robTagT'(i), branchOpE'(randBits(3)), a, b, 0, 1,
                          robTagT'(8 + i), 0, 1, 0);
      cdbValid = 1'b0;
    end
    waitDrained(-1);
    reportTest("same-cycle bypass", errBefore);

    // rob 8 refills entry 1, so age order differs from index order.
    errBefore = errors;
    a = randBits(32);
    dispatchBranch(4, branchOpE'(randBits(3)), a, randBits(32), 0, 1, 12, 0, 0, 1);
    dispatchBranch(5, branchOpE'(randBits(3)), randBits(32), randBits(32), 0, 1, 13, 0, 0, 0);
    dispatchBranch(6, branchOpE'(randBits(3)), a, randBits(32), 0, 1, 12, 0, 0, 1);
    dispatchBranch(7, branchOpE'(randBits(3)), a, randBits(32), 0, 1, 12, 0, 0, 1);
    broadcastTag(13);
    waitDrained(5);
    dispatchBranch(8, branchOpE'(randBits(3)), a, randBits(32), 0, 1, 12, 0, 0, 1);
    lastOrderCycle = 0;
    broadcastTag(12);
    waitDrained(-1);
    checks++;
    if (orderQ.size() != 0) begin
      errors++;
      $display("ERROR @%0t: %0d ordered branches never resolved", $time, orderQ.size());
    end
    reportTest("oldest first", errBefore);

    errBefore = errors;
    for (int i = 0; i < `BR_RS_ENTRIES; i++) begin
      checks++;
      if (dispatchFull) begin
        errors++;
        $display("ERROR @%0t: full with only %0d entries used", $time, i);
      end
      a = randBits(32);
      dispatchBranch(robTagT'(i), branchOpE'(randBits(3)), a, randBits(32), 0, 1,
                     robTagT'(8 + i), 0, 0, 0);
    end
    checks++;
    if (!dispatchFull) begin
      errors++;
      $display("ERROR @%0t: not full with every entry waiting", $time);
    end
    broadcastTag(8);
    spins = 0;
    while (dispatchFull) begin
      idleCycles(1);
      spins++;
      if (spins > 20) abortRun("station stayed full after a wakeup");
    end
    waitDrained(0);
    // refill the drained entry so the flush hits a full station.
    dispatchBranch(4, branchOpE'(randBits(3)), randBits(32), randBits(32), 0, 1, 8, 0, 0, 0);
    flush = 1'b1;
    idleCycles(1);
    flush = 1'b0;
    for (int r = 0; r < NumTags; r++) pending[r] = 1'b0;  // flushed branches must never resolve.
    checks++;
    if (dispatchFull) begin
      errors++;
      $display("ERROR @%0t: still full after flush", $time);
    end
    for (int i = 0; i < `BR_RS_ENTRIES; i++) broadcastTag(robTagT'(8 + i));
    idleCycles(5);
    for (int i = 0; i < 4; i++) begin
      a = randBits(32);
      dispatchBranch(robTagT'(i), branchOpE'(randBits(3)), a, randBits(32), 1, 1, 0, 0, 1, 0);
    end
    waitDrained(-1);
    reportTest("full station and flush", errBefore);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
design/branchIsaPkg.sv
design/rsPkg.sv
design/rsWriteIf.sv
design/branchIssueIf.sv
design/branchDispatch.sv
design/branchRSEntry.sv
design/branchSelect.sv
design/branchRS.sv
design/branchExecute.sv
design/branchUnitTop.sv
dv/branchUnitTb.sv

// File: Bender.yml
package:
  name: branch_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/branchIsaPkg.sv
      - design/rsPkg.sv
      - design/rsWriteIf.sv
      - design/branchIssueIf.sv
      - design/branchDispatch.sv
      - design/branchRSEntry.sv
      - design/branchSelect.sv
      - design/branchRS.sv
      - design/branchExecute.sv
      - design/branchUnitTop.sv
  - target: test
    include_dirs:
      - include
    files:
      - dv/branchUnitTb.sv
